/* hw/rc5ParamsPkg.sv */
package rc5ParamsPkg;

    // RC5-32/12 with a 16-byte key
    localparam int WordWidth = 32;
    localparam int BlockWidth = 2 * WordWidth;
    localparam int KeyWidth = 128;
    localparam int KeyWords = KeyWidth / WordWidth;
    localparam int Rounds = 12;

    // Expanded key table and its mixing length
    localparam int TableSize = 2 * Rounds + 2;
    localparam int MixSteps = 3 * TableSize;
    localparam int RotWidth = $clog2(WordWidth);

    // Odd constants derived from e and the golden ratio
    localparam logic [WordWidth-1:0] MagicP = 32'hB7E15163;
    localparam logic [WordWidth-1:0] MagicQ = 32'h9E3779B9;

    // Input whitening, one register per round, output unwhitening
    localparam int Latency = Rounds + 2;

endpackage

/* hw/rc5TypesPkg.sv */
package rc5TypesPkg;

    // Block halves, A is the upper word
    typedef struct packed {
        logic [rc5ParamsPkg::WordWidth-1:0] a;
        logic [rc5ParamsPkg::WordWidth-1:0] b;
    } rc5Halves;

    // Raw at the ports, split into halves by the round logic
    typedef union packed {
        logic [rc5ParamsPkg::BlockWidth-1:0] raw;
        rc5Halves half;
    } rc5Block;

endpackage

/* hw/rc5KeySchedule.sv */
`timescale 1ns/1ps

module rc5KeySchedule (
    input  logic clk,
    input  logic clr,
    input  logic i_keyLoad,
    input  logic [rc5ParamsPkg::KeyWidth-1:0] i_key,
    output logic o_keyReady,
    output logic [rc5ParamsPkg::TableSize-1:0][rc5ParamsPkg::WordWidth-1:0] o_roundKeys
);

    localparam int WordWidth = rc5ParamsPkg::WordWidth;
    localparam int TableSize = rc5ParamsPkg::TableSize;
    localparam int KeyWords = rc5ParamsPkg::KeyWords;
    localparam int RotWidth = rc5ParamsPkg::RotWidth;
    localparam int TableIdxWidth = $clog2(TableSize);
    localparam int KeyIdxWidth = $clog2(KeyWords);
    localparam int StepWidth = $clog2(rc5ParamsPkg::MixSteps);

    logic [TableSize-1:0][WordWidth-1:0] keyTable;
    logic [KeyWords-1:0][WordWidth-1:0] keyWords;
    logic [WordWidth-1:0] regA;
    logic [WordWidth-1:0] regB;
    logic [TableIdxWidth-1:0] idxI;
    logic [KeyIdxWidth-1:0] idxJ;
    logic [StepWidth-1:0] stepCnt;
    logic mixing;

    logic [WordWidth-1:0] sumA;
    logic [WordWidth-1:0] mixA;
    logic [WordWidth-1:0] sumB;
    logic [WordWidth-1:0] mixB;
    logic [RotWidth-1:0] rotB;

    ////////////////////////////////////////////////////////////
    // One mixing step
    ////////////////////////////////////////////////////////////

    always_comb begin
        sumA = keyTable[idxI] + regA + regB;
        // Fixed rotate left by 3
        mixA = {sumA[WordWidth-4:0], sumA[WordWidth-1:WordWidth-3]};
        sumB = keyWords[idxJ] + mixA + regB;
        rotB = RotWidth'(mixA + regB);
        mixB = (sumB << rotB) | (sumB >> (WordWidth - rotB));
    end

    // Table, key words and mixing registers
    always_ff @(posedge clk) begin
        if (i_keyLoad) begin
            for (int k = 0; k < TableSize; k++) begin
                keyTable[k] <= rc5ParamsPkg::MagicP + WordWidth'(k) * rc5ParamsPkg::MagicQ;
            end
            keyWords <= i_key;
            regA <= '0;
            regB <= '0;
        end else if (mixing) begin
            keyTable[idxI] <= mixA;
            keyWords[idxJ] <= mixB;
            regA <= mixA;
            regB <= mixB;
        end
    end

    ////////////////////////////////////////////////////////////
    // Step sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            mixing <= 1'b0;
            o_keyReady <= 1'b0;
            stepCnt <= '0;
            idxI <= '0;
            idxJ <= '0;
        end else if (i_keyLoad) begin
            // A new key restarts the whole count
            mixing <= 1'b1;
            o_keyReady <= 1'b0;
            stepCnt <= '0;
            idxI <= '0;
            idxJ <= '0;
        end else if (mixing) begin
            idxI <= (idxI == TableIdxWidth'(TableSize - 1)) ? '0 : idxI + 1'b1;
            idxJ <= idxJ + 1'b1;
            stepCnt <= stepCnt + 1'b1;
            // Last step writes its word on this edge
            if (stepCnt == StepWidth'(rc5ParamsPkg::MixSteps - 1)) begin
                mixing <= 1'b0;
                o_keyReady <= 1'b1;
            end
        end
    end

    assign o_roundKeys = keyTable;

endmodule

/* hw/rc5RoundStage.sv */
`timescale 1ns/1ps

module rc5RoundStage (
    input  logic clk,
    input  logic clr,
    input  logic i_valid,
    input  logic i_decrypt,
    input  logic [rc5ParamsPkg::BlockWidth-1:0] i_block,
    input  logic [rc5ParamsPkg::WordWidth-1:0] i_keyA,
    input  logic [rc5ParamsPkg::WordWidth-1:0] i_keyB,
    output logic o_valid,
    output logic o_decrypt,
    output logic [rc5ParamsPkg::BlockWidth-1:0] o_block
);

    localparam int WordWidth = rc5ParamsPkg::WordWidth;
    localparam int RotWidth = rc5ParamsPkg::RotWidth;

    rc5TypesPkg::rc5Block inBlk;
    rc5TypesPkg::rc5Block nextBlk;
    rc5TypesPkg::rc5Block outBlk;

    logic [WordWidth-1:0] encTmpA;
    logic [WordWidth-1:0] encTmpB;
    logic [WordWidth-1:0] decTmpA;
    logic [WordWidth-1:0] decTmpB;
    logic [RotWidth-1:0] encAmtA;
    logic [RotWidth-1:0] encAmtB;
    logic [RotWidth-1:0] decAmtA;
    logic [RotWidth-1:0] decAmtB;

    assign inBlk.raw = i_block;

    always_comb begin
        // Forward round, A first then B
        encTmpA = inBlk.half.a ^ inBlk.half.b;
        encAmtA = inBlk.half.b[RotWidth-1:0];
        nextBlk.half.a = ((encTmpA << encAmtA) | (encTmpA >> (WordWidth - encAmtA))) + i_keyA;
        encTmpB = inBlk.half.b ^ nextBlk.half.a;
        encAmtB = nextBlk.half.a[RotWidth-1:0];
        nextBlk.half.b = ((encTmpB << encAmtB) | (encTmpB >> (WordWidth - encAmtB))) + i_keyB;

        // Inverse round undoes B before A
        decTmpB = inBlk.half.b - i_keyB;
        decAmtB = inBlk.half.a[RotWidth-1:0];
        if (i_decrypt) begin
            nextBlk.half.b = ((decTmpB >> decAmtB) | (decTmpB << (WordWidth - decAmtB)))
                             ^ inBlk.half.a;
        end
        decTmpA = inBlk.half.a - i_keyA;
        decAmtA = nextBlk.half.b[RotWidth-1:0];
        if (i_decrypt) begin
            nextBlk.half.a = ((decTmpA >> decAmtA) | (decTmpA << (WordWidth - decAmtA)))
                             ^ nextBlk.half.b;
        end
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_valid <= 1'b0;
            o_decrypt <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_decrypt <= i_decrypt;
        end
    end

    always_ff @(posedge clk) begin
        outBlk <= nextBlk;
    end

    assign o_block = outBlk.raw;

endmodule

/* hw/rc5Datapath.sv */
`timescale 1ns/1ps

module rc5Datapath (
    input  logic clk,
    input  logic clr,
    input  logic i_valid,
    input  logic i_decrypt,
    input  logic [rc5ParamsPkg::BlockWidth-1:0] i_block,
    input  logic [rc5ParamsPkg::TableSize-1:0][rc5ParamsPkg::WordWidth-1:0] i_roundKeys,
    output logic o_valid,
    output logic o_decrypt,
    output logic [rc5ParamsPkg::BlockWidth-1:0] o_block
);

    localparam int Rounds = rc5ParamsPkg::Rounds;
    localparam int TableSize = rc5ParamsPkg::TableSize;

    rc5TypesPkg::rc5Block inBlk;
    rc5TypesPkg::rc5Block frontNext;
    rc5TypesPkg::rc5Block frontBlk;
    rc5TypesPkg::rc5Block lastBlk;
    rc5TypesPkg::rc5Block backNext;
    rc5TypesPkg::rc5Block backBlk;
    logic frontValid;
    logic frontDecrypt;

    // Index 0 is the whitening register, r+1 the output of round r
    wire [Rounds:0] stageValid;
    wire [Rounds:0] stageDecrypt;
    wire [Rounds:0][rc5ParamsPkg::BlockWidth-1:0] stageBlock;

    ////////////////////////////////////////////////////////////
    // Input whitening
    ////////////////////////////////////////////////////////////

    assign inBlk.raw = i_block;

    always_comb begin
        frontNext = inBlk;
        if (!i_decrypt) begin
            frontNext.half.a = inBlk.half.a + i_roundKeys[0];
            frontNext.half.b = inBlk.half.b + i_roundKeys[1];
        end
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            frontValid <= 1'b0;
            frontDecrypt <= 1'b0;
        end else begin
            frontValid <= i_valid;
            frontDecrypt <= i_decrypt;
        end
    end

    always_ff @(posedge clk) begin
        frontBlk <= frontNext;
    end

    assign stageValid[0] = frontValid;
    assign stageDecrypt[0] = frontDecrypt;
    assign stageBlock[0] = frontBlk.raw;

    ////////////////////////////////////////////////////////////
    // Rounds, keys picked by each block's own mode
    ////////////////////////////////////////////////////////////

    for (genvar r = 0; r < Rounds; r++) begin : genRound
        rc5RoundStage round_i (
            .clk       (clk),
            .clr       (clr),
            .i_valid   (stageValid[r]),
            .i_decrypt (stageDecrypt[r]),
            .i_block   (stageBlock[r]),
            .i_keyA    (stageDecrypt[r] ? i_roundKeys[TableSize - 2 - 2*r] : i_roundKeys[2*r + 2]),
            .i_keyB    (stageDecrypt[r] ? i_roundKeys[TableSize - 1 - 2*r] : i_roundKeys[2*r + 3]),
            .o_valid   (stageValid[r+1]),
            .o_decrypt (stageDecrypt[r+1]),
            .o_block   (stageBlock[r+1])
        );
    end

    ////////////////////////////////////////////////////////////
    // Output unwhitening
    ////////////////////////////////////////////////////////////

    assign lastBlk.raw = stageBlock[Rounds];

    always_comb begin
        backNext = lastBlk;
        if (stageDecrypt[Rounds]) begin
            backNext.half.a = lastBlk.half.a - i_roundKeys[0];
            backNext.half.b = lastBlk.half.b - i_roundKeys[1];
        end
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_valid <= 1'b0;
            o_decrypt <= 1'b0;
        end else begin
            o_valid <= stageValid[Rounds];
            o_decrypt <= stageDecrypt[Rounds];
        end
    end

    always_ff @(posedge clk) begin
        backBlk <= backNext;
    end

    assign o_block = backBlk.raw;

endmodule

/* hw/rc5Top.sv */
`timescale 1ns/1ps

module rc5Top (
    input  logic clk,
    input  logic clr,
    input  logic i_keyLoad,
    input  logic [rc5ParamsPkg::KeyWidth-1:0] i_key,
    input  logic i_valid,
    input  logic i_decrypt,
    input  logic [$bits(rc5TypesPkg::rc5Block)-1:0] i_block,
    output logic o_keyReady,
    output logic o_valid,
    output logic o_decrypt,
    output logic [$bits(rc5TypesPkg::rc5Block)-1:0] o_block
);

    // Expanded table, held stable between key loads
    logic [rc5ParamsPkg::TableSize-1:0][rc5ParamsPkg::WordWidth-1:0] roundKeys;

    rc5KeySchedule keySched_i (
        .clk         (clk),
        .clr         (clr),
        .i_keyLoad   (i_keyLoad),
        .i_key       (i_key),
        .o_keyReady  (o_keyReady),
        .o_roundKeys (roundKeys)
    );

    rc5Datapath datapath_i (
        .clk         (clk),
        .clr         (clr),
        .i_valid     (i_valid),
        .i_decrypt   (i_decrypt),
        .i_block     (i_block),
        .i_roundKeys (roundKeys),
        .o_valid     (o_valid),
        .o_decrypt   (o_decrypt),
        .o_block     (o_block)
    );

endmodule

/* tests/rc5Tb_assert.sv */
`timescale 1ns/1ps

module rc5Tb_assert (
    input logic clk,
    input logic clr,
    input logic i_keyLoad,
    input logic i_valid,
    input logic i_decrypt,
    input logic i_keyReady,
    input logic i_outValid,
    input logic i_outDecrypt
);

    localparam int Latency = rc5ParamsPkg::Latency;
    // Init cycle plus the mixing steps
    localparam int KeyCycles = rc5ParamsPkg::MixSteps + 1;

    // Failed assertions so far, read back at the end of the run
    int failCount = 0;

    ////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////

    resetQuiet: assert property (@(posedge clk) clr |-> !i_outValid && !i_keyReady)
        else begin
            failCount++;
            $error("Output valid or key ready high while reset is applied");
        end

    resetRelease: assert property (@(posedge clk) $fell(clr) |=> !i_outValid && !i_keyReady)
        else begin
            failCount++;
            $error("Output valid or key ready high on the first cycle after reset");
        end

    ////////////////////////////////////////////////////////////
    // Datapath latency and key load length
    ////////////////////////////////////////////////////////////

    blockLatency: assert property (@(posedge clk) disable iff (clr)
        (i_valid && i_keyReady) |-> ##Latency
            (i_outValid && i_outDecrypt == $past(i_decrypt, Latency)))
        else begin
            failCount++;
            $error("Block did not leave the pipeline with its mode after the expected latency");
        end

    keyBusy: assert property (@(posedge clk) disable iff (clr) i_keyLoad |=> !i_keyReady)
        else begin
            failCount++;
            $error("Key ready still high one cycle after a key load");
        end

    keyDone: assert property (@(posedge clk) disable iff (clr) i_keyLoad |-> ##KeyCycles i_keyReady)
        else begin
            failCount++;
            $error("Key ready not high at the end of the key expansion");
        end

endmodule

bind rc5Top rc5Tb_assert timing_i (
    .clk          (clk),
    .clr          (clr),
    .i_keyLoad    (i_keyLoad),
    .i_valid      (i_valid),
    .i_decrypt    (i_decrypt),
    .i_keyReady   (o_keyReady),
    .i_outValid   (o_valid),
    .i_outDecrypt (o_decrypt)
);

/* include/rc5Model.svh */
`ifndef RC5_MODEL_SVH
`define RC5_MODEL_SVH

typedef logic [rc5ParamsPkg::TableSize-1:0][rc5ParamsPkg::WordWidth-1:0] roundKeyTable;

function automatic logic [31:0] rotateLeft(logic [31:0] x, logic [4:0] n);
    return (x << n) | (x >> (32 - n));
endfunction

function automatic logic [31:0] rotateRight(logic [31:0] x, logic [4:0] n);
    return (x >> n) | (x << (32 - n));
endfunction

// Standard RC5 schedule, three passes over the table
function automatic roundKeyTable expandKey(logic [127:0] key);
    roundKeyTable s;
    logic [3:0][31:0] l;
    logic [31:0] a;
    logic [31:0] b;
    int i;
    int j;
    for (int k = 0; k < rc5ParamsPkg::TableSize; k++) begin
        s[k] = rc5ParamsPkg::MagicP + k * rc5ParamsPkg::MagicQ;
    end
    l = key;
    a = '0;
    b = '0;
    i = 0;
    j = 0;
    for (int step = 0; step < rc5ParamsPkg::MixSteps; step++) begin
        a = rotateLeft(s[i] + a + b, 5'd3);
        b = rotateLeft(l[j] + a + b, 5'(a + b));
        s[i] = a;
        l[j] = b;
        i = (i + 1) % rc5ParamsPkg::TableSize;
        j = (j + 1) % rc5ParamsPkg::KeyWords;
    end
    return s;
endfunction

function automatic logic [63:0] encryptBlock(roundKeyTable s, logic [63:0] blk);
    logic [31:0] a;
    logic [31:0] b;
    a = blk[63:32] + s[0];
    b = blk[31:0] + s[1];
    for (int r = 1; r <= rc5ParamsPkg::Rounds; r++) begin
        a = rotateLeft(a ^ b, b[4:0]) + s[2*r];
        b = rotateLeft(b ^ a, a[4:0]) + s[2*r + 1];
    end
    return {a, b};
endfunction

function automatic logic [63:0] decryptBlock(roundKeyTable s, logic [63:0] blk);
    logic [31:0] a;
    logic [31:0] b;
    a = blk[63:32];
    b = blk[31:0];
    for (int r = rc5ParamsPkg::Rounds; r >= 1; r--) begin
        b = rotateRight(b - s[2*r + 1], a[4:0]) ^ a;
        a = rotateRight(a - s[2*r], b[4:0]) ^ b;
    end
    return {a - s[0], b - s[1]};
endfunction

`endif

/* tests/rc5Tb.sv */
`timescale 1ns/1ps

module rc5Tb;

    // Budget for the whole run, from key loads, blocks and pipeline drains
    localparam int NumKeyLoads = 4;
    localparam int NumBlocks = 105;
    localparam int NumTests = 6;
    localparam int TimeoutLimit = (NumKeyLoads * (rc5ParamsPkg::MixSteps + 1) + NumBlocks
                                   + rc5ParamsPkg::Latency * NumTests) * 2;

    `include "rc5Model.svh"

    logic clk = 1'b0;
    logic clr;
    logic i_keyLoad;
    logic [rc5ParamsPkg::KeyWidth-1:0] i_key;
    logic i_valid;
    logic i_decrypt;
    logic [rc5ParamsPkg::BlockWidth-1:0] i_block;
    logic o_keyReady;
    logic o_valid;
    logic o_decrypt;
    logic [rc5ParamsPkg::BlockWidth-1:0] o_block;

    int seed = 32'ha0cc007a;
    int cycleCount = 0;
    int mismatchCount = 0;
    int strayCount = 0;
    string testName = "";
    roundKeyTable keyTable;

    // Expected results in send order
    logic [63:0] expQ[$];
    bit modeQ[$];
    string nameQ[$];

    always #10 clk = ~clk;

    rc5Top dut_i (
        .clk        (clk),
        .clr        (clr),
        .i_keyLoad  (i_keyLoad),
        .i_key      (i_key),
        .i_valid    (i_valid),
        .i_decrypt  (i_decrypt),
        .i_block    (i_block),
        .o_keyReady (o_keyReady),
        .o_valid    (o_valid),
        .o_decrypt  (o_decrypt),
        .o_block    (o_block)
    );

    ////////////////////////////////////////////////////////////
    // Timeout and output checking
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutLimit) begin
            $display("Timeout after %0d cycles, %0d blocks never came out", cycleCount,
                     expQ.size());
            $display("Some tests failed");
            $finish;
        end
    end

    // Outputs settle after the rising edge, so look at them half a cycle later
    always @(negedge clk) begin : checkOutput
        logic [63:0] expBlk;
        bit expMode;
        string expName;
        if (!clr && o_valid) begin
            assert (expQ.size() != 0) else begin
                strayCount++;
                $error("Output block %h arrived with no block pending", o_block);
            end
            if (expQ.size() != 0) begin
                expBlk = expQ.pop_front();
                expMode = modeQ.pop_front();
                expName = nameQ.pop_front();
                assert (o_block == expBlk && o_decrypt == expMode) else begin
                    mismatchCount++;
                    $error("Mismatch in %s: expected %h (decrypt %0b), actual %h (decrypt %0b)",
                           expName, expBlk, expMode, o_block, o_decrypt);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [63:0] randomBlock();
        logic [63:0] blk;
        blk[63:32] = $random(seed);
        blk[31:0] = $random(seed);
        return blk;
    endfunction

    function automatic logic [127:0] randomKey();
        logic [127:0] key;
        for (int w = 0; w < 4; w++) begin
            key[32*w +: 32] = $random(seed);
        end
        return key;
    endfunction

    task automatic applyReset();
        @(negedge clk);
        clr = 1'b1;
        repeat (10) @(negedge clk);
        clr = 1'b0;
    endtask

    // Pulse the load for one cycle, then wait for the table
    task automatic loadKey(input logic [127:0] key);
        @(negedge clk);
        i_keyLoad = 1'b1;
        i_key = key;
        @(negedge clk);
        i_keyLoad = 1'b0;
        keyTable = expandKey(key);
        while (!o_keyReady) @(negedge clk);
    endtask

    task automatic sendBlock(input bit decrypt, input logic [63:0] blk,
                             input logic [63:0] expected);
        @(negedge clk);
        i_valid = 1'b1;
        i_decrypt = decrypt;
        i_block = blk;
        expQ.push_back(expected);
        modeQ.push_back(decrypt);
        nameQ.push_back(testName);
    endtask

    task automatic sendEncrypt(input logic [63:0] blk);
        sendBlock(1'b0, blk, encryptBlock(keyTable, blk));
    endtask

    task automatic sendDecrypt(input logic [63:0] blk);
        sendBlock(1'b1, blk, decryptBlock(keyTable, blk));
    endtask

    task automatic drainOutputs();
        @(negedge clk);
        i_valid = 1'b0;
        while (expQ.size() != 0) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : mainSequence
        logic [63:0] plain;
        clr = 1'b1;
        i_keyLoad = 1'b0;
        i_key = '0;
        i_valid = 1'b0;
        i_decrypt = 1'b0;
        i_block = '0;
        repeat (10) @(negedge clk);
        clr = 1'b0;

        testName = "zeroKey";
        loadKey('0);
        sendEncrypt('0);
        drainOutputs();

        // One block per cycle
        testName = "encBurst";
        loadKey(randomKey());
        repeat (40) sendEncrypt(randomBlock());
        drainOutputs();

        testName = "decrypt";
        repeat (16) sendDecrypt(randomBlock());
        repeat (16) begin
            plain = randomBlock();
            sendBlock(1'b1, encryptBlock(keyTable, plain), plain);
        end
        drainOutputs();

        testName = "mixedModes";
        for (int n = 0; n < 20; n++) begin
            if (n[0]) sendDecrypt(randomBlock());
            else sendEncrypt(randomBlock());
        end
        drainOutputs();

        testName = "newKey";
        loadKey(randomKey());
        for (int n = 0; n < 10; n++) begin
            if (n % 3 == 0) sendDecrypt(randomBlock());
            else sendEncrypt(randomBlock());
        end
        drainOutputs();

        // Idle gap catches any output without a block behind it
        testName = "afterReset";
        applyReset();
        repeat (20) @(negedge clk);
        loadKey(randomKey());
        sendEncrypt(randomBlock());
        sendDecrypt(randomBlock());
        drainOutputs();

        repeat (4) @(negedge clk);
        $display("Errors: %0d mismatches, %0d stray outputs, %0d timing assertions",
                 mismatchCount, strayCount, dut_i.timing_i.failCount);
        if (mismatchCount + strayCount + dut_i.timing_i.failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/rc5ParamsPkg.sv
hw/rc5TypesPkg.sv
hw/rc5KeySchedule.sv
hw/rc5RoundStage.sv
hw/rc5Datapath.sv
hw/rc5Top.sv
tests/rc5Tb_assert.sv
tests/rc5Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the RC5 testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rc5Tb -f filelist.f \
    -Mdir obj_dir -o rc5Sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rc5Sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log && exit 0 || exit 1
